//--- Bender.yml
package:
  name: dual_issue

sources:
  - hdl/dual_issue_pkg.sv
  - hdl/regfile.sv
  - hdl/alu_lane.sv
  - hdl/commit_stage.sv
  - hdl/issue_dispatch.sv
  - hdl/dual_issue_top.sv
  - target: test
    files:
      - testbench/tb_dual_issue_top.sv

//--- dual_issue.f
hdl/dual_issue_pkg.sv
hdl/regfile.sv
hdl/alu_lane.sv
hdl/commit_stage.sv
hdl/issue_dispatch.sv
hdl/dual_issue_top.sv
testbench/tb_dual_issue_top.sv

//--- hdl/alu_lane.sv
`timescale 1ns/1ps
`default_nettype none

module alu_lane import dual_issue_pkg::*; (
    input  wire          clk,
    input  wire          arst_n_i,
    input  issue_slot_t  slot_i,
    output lane_result_t fwd_o,
    output lane_result_t res_o
);

    logic [XLEN-1:0] result;

    always_comb begin
        case (slot_i.alu_op)
            ALU_ADD: result = slot_i.operand_a + slot_i.operand_b;
            ALU_SUB: result = slot_i.operand_a - slot_i.operand_b;
            ALU_SLT: begin
                result = ($signed(slot_i.operand_a) < $signed(slot_i.operand_b))
                         ? XLEN'(1) : '0;
            end
            ALU_AND: result = slot_i.operand_a & slot_i.operand_b;
            ALU_OR:  result = slot_i.operand_a | slot_i.operand_b;
            ALU_XOR: result = slot_i.operand_a ^ slot_i.operand_b;
            default: result = '0;  // Unknown word
        endcase
    end

    // Current-cycle result, newest forwarding source
    always_comb begin
        fwd_o.valid = slot_i.valid;
        fwd_o.pc    = slot_i.pc;
        fwd_o.we    = slot_i.valid && slot_i.we;
        fwd_o.waddr = slot_i.waddr;
        fwd_o.wdata = result;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            res_o <= '0;
        end else begin
            res_o <= fwd_o;
        end
    end

endmodule

`default_nettype wire

//--- hdl/commit_stage.sv
`timescale 1ns/1ps
`default_nettype none

module commit_stage import dual_issue_pkg::*; (
    input  wire                           clk,
    input  wire                           arst_n_i,
    input  lane_result_t [NUM_LANES-1:0]  res_i,
    output reg_write_t   [NUM_LANES-1:0]  rf_wr_o,
    output lane_result_t [NUM_LANES-1:0]  commit_o
);

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            rf_wr_o[i].we    = res_i[i].valid && res_i[i].we;
            rf_wr_o[i].waddr = res_i[i].waddr;
            rf_wr_o[i].wdata = res_i[i].wdata;
            // Younger lane owns a shared destination
            for (int j = i + 1; j < NUM_LANES; j++) begin
                if (res_i[j].valid && res_i[j].we && res_i[j].waddr == res_i[i].waddr) begin
                    rf_wr_o[i].we = 1'b0;
                end
            end
        end
    end

    // Debug commit ports keep each lane's own we and wdata
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            commit_o <= '0;
        end else begin
            commit_o <= res_i;
        end
    end

endmodule

`default_nettype wire

//--- hdl/dual_issue_pkg.sv
`default_nettype none

package dual_issue_pkg;

    localparam int XLEN           = 32;
    localparam int NUM_LANES      = 2;
    localparam int REG_ADDR_W     = 5;
    localparam int NUM_REGS       = 32;
    localparam int INSTR_BYTES    = 4;
    localparam int NUM_READ_PORTS = 2 * NUM_LANES;  // rj and rk per lane

    // 3R opcodes, instruction bits 31:15
    localparam logic [16:0] OP_ADD_W = 17'h00020;
    localparam logic [16:0] OP_SUB_W = 17'h00022;
    localparam logic [16:0] OP_SLT   = 17'h00024;
    localparam logic [16:0] OP_AND   = 17'h00029;
    localparam logic [16:0] OP_OR    = 17'h0002a;
    localparam logic [16:0] OP_XOR   = 17'h0002b;

    // 2RI12 opcodes, instruction bits 31:22
    localparam logic [9:0] OP_ADDI_W = 10'h00a;
    localparam logic [9:0] OP_ANDI   = 10'h00d;
    localparam logic [9:0] OP_ORI    = 10'h00e;
    localparam logic [9:0] OP_XORI   = 10'h00f;

    typedef struct packed {
        logic [16:0]           opcode;
        logic [REG_ADDR_W-1:0] rk;
        logic [REG_ADDR_W-1:0] rj;
        logic [REG_ADDR_W-1:0] rd;
    } instr_3r_t;

    typedef struct packed {
        logic [9:0]            opcode;
        logic [11:0]           si12;
        logic [REG_ADDR_W-1:0] rj;
        logic [REG_ADDR_W-1:0] rd;
    } instr_2ri12_t;

    // Same word, two field layouts
    typedef union packed {
        instr_3r_t    fmt_3r;
        instr_2ri12_t fmt_2ri12;
    } instr_t;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        alu_op_e               alu_op;
        logic [XLEN-1:0]       operand_a;
        logic [XLEN-1:0]       operand_b;  // Immediate already extended
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
    } issue_slot_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } lane_result_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } reg_write_t;

endpackage

`default_nettype wire

//--- hdl/dual_issue_top.sv
`timescale 1ns/1ps
`default_nettype none

module dual_issue_top import dual_issue_pkg::*; (
    input  wire                           clk,
    input  wire                           arst_n_i,
    input  wire                           pair_valid_i,  // One-cycle strobe per pair
    input  wire  [XLEN-1:0]               pair_pc_i,
    input  instr_t       [NUM_LANES-1:0]  pair_instr_i,
    output lane_result_t [NUM_LANES-1:0]  commit_o
);

    issue_slot_t  [NUM_LANES-1:0] slot;
    lane_result_t [NUM_LANES-1:0] lane_fwd;  // Combinational lane results
    lane_result_t [NUM_LANES-1:0] lane_res;  // Registered lane results
    reg_write_t   [NUM_LANES-1:0] rf_wr;

    logic [NUM_READ_PORTS-1:0][REG_ADDR_W-1:0] rf_raddr;
    logic [NUM_READ_PORTS-1:0][XLEN-1:0]       rf_rdata;

    issue_dispatch u_issue_dispatch (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .pair_valid_i (pair_valid_i),
        .pair_pc_i    (pair_pc_i),
        .pair_instr_i (pair_instr_i),
        .lane_fwd_i   (lane_fwd),
        .lane_res_i   (lane_res),
        .rf_raddr_o   (rf_raddr),
        .rf_rdata_i   (rf_rdata),
        .slot_o       (slot)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        alu_lane u_alu_lane (
            .clk      (clk),
            .arst_n_i (arst_n_i),
            .slot_i   (slot[i]),
            .fwd_o    (lane_fwd[i]),
            .res_o    (lane_res[i])
        );
    end

    commit_stage u_commit_stage (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .res_i    (lane_res),
        .rf_wr_o  (rf_wr),
        .commit_o (commit_o)
    );

    regfile u_regfile (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wr_i     (rf_wr),
        .raddr_i  (rf_raddr),
        .rdata_o  (rf_rdata)
    );

endmodule

`default_nettype wire

//--- hdl/issue_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module issue_dispatch import dual_issue_pkg::*; (
    input  wire                                            clk,
    input  wire                                            arst_n_i,
    input  wire                                            pair_valid_i,
    input  wire  [XLEN-1:0]                                pair_pc_i,
    input  instr_t       [NUM_LANES-1:0]                   pair_instr_i,
    input  lane_result_t [NUM_LANES-1:0]                   lane_fwd_i,
    input  lane_result_t [NUM_LANES-1:0]                   lane_res_i,
    output logic         [NUM_READ_PORTS-1:0][REG_ADDR_W-1:0] rf_raddr_o,
    input  wire          [NUM_READ_PORTS-1:0][XLEN-1:0]    rf_rdata_i,
    output issue_slot_t  [NUM_LANES-1:0]                   slot_o
);

    issue_slot_t [NUM_LANES-1:0]           slot_d;
    logic        [NUM_LANES-1:0]           use_imm;
    logic        [NUM_LANES-1:0][XLEN-1:0] imm;

    function automatic logic hits(
        input lane_result_t          src,
        input logic [REG_ADDR_W-1:0] addr
    );
        return src.valid && src.we && (src.waddr == addr) && (addr != '0);
    endfunction

    // Later matches override earlier ones, so lane 1 beats lane 0
    // and the ALU output beats the registered result
    function automatic logic [XLEN-1:0] resolve(
        input logic [REG_ADDR_W-1:0]       addr,
        input logic [XLEN-1:0]             rf_val,
        input lane_result_t [NUM_LANES-1:0] newer,
        input lane_result_t [NUM_LANES-1:0] older
    );
        logic [XLEN-1:0] val;
        val = rf_val;
        for (int j = 0; j < NUM_LANES; j++) begin
            if (hits(older[j], addr)) begin
                val = older[j].wdata;
            end
        end
        for (int j = 0; j < NUM_LANES; j++) begin
            if (hits(newer[j], addr)) begin
                val = newer[j].wdata;
            end
        end
        return val;
    endfunction

    always_comb begin
        slot_d  = '0;
        use_imm = '0;
        imm     = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            rf_raddr_o[2*i]   = pair_instr_i[i].fmt_3r.rj;
            rf_raddr_o[2*i+1] = pair_instr_i[i].fmt_3r.rk;  // Don't care for 2RI12

            slot_d[i].valid = pair_valid_i;
            slot_d[i].pc    = pair_pc_i + XLEN'(i * INSTR_BYTES);
            slot_d[i].waddr = pair_instr_i[i].fmt_3r.rd;

            case (pair_instr_i[i].fmt_3r.opcode)
                OP_ADD_W: slot_d[i].alu_op = ALU_ADD;
                OP_SUB_W: slot_d[i].alu_op = ALU_SUB;
                OP_SLT:   slot_d[i].alu_op = ALU_SLT;
                OP_AND:   slot_d[i].alu_op = ALU_AND;
                OP_OR:    slot_d[i].alu_op = ALU_OR;
                OP_XOR:   slot_d[i].alu_op = ALU_XOR;
                default: begin
                    // Not 3R, try the immediate view
                    use_imm[i] = 1'b1;
                    imm[i]     = {20'b0, pair_instr_i[i].fmt_2ri12.si12};
                    case (pair_instr_i[i].fmt_2ri12.opcode)
                        OP_ADDI_W: begin
                            slot_d[i].alu_op = ALU_ADD;
                            imm[i] = {{20{pair_instr_i[i].fmt_2ri12.si12[11]}},
                                      pair_instr_i[i].fmt_2ri12.si12};
                        end
                        OP_ANDI: slot_d[i].alu_op = ALU_AND;
                        OP_ORI:  slot_d[i].alu_op = ALU_OR;
                        OP_XORI: slot_d[i].alu_op = ALU_XOR;
                        default: slot_d[i].alu_op = ALU_NOP;
                    endcase
                end
            endcase

            slot_d[i].we = pair_valid_i && (slot_d[i].alu_op != ALU_NOP)
                           && (slot_d[i].waddr != '0);

            // Both lanes see pre-pair state only
            slot_d[i].operand_a = resolve(rf_raddr_o[2*i], rf_rdata_i[2*i],
                                          lane_fwd_i, lane_res_i);
            slot_d[i].operand_b = use_imm[i] ? imm[i]
                                : resolve(rf_raddr_o[2*i+1], rf_rdata_i[2*i+1],
                                          lane_fwd_i, lane_res_i);
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            slot_o <= '0;
        end else begin
            slot_o <= slot_d;
        end
    end

endmodule

`default_nettype wire

//--- hdl/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile import dual_issue_pkg::*; (
    input  wire                                          clk,
    input  wire                                          arst_n_i,
    input  reg_write_t [NUM_LANES-1:0]                   wr_i,
    input  wire        [NUM_READ_PORTS-1:0][REG_ADDR_W-1:0] raddr_i,
    output logic       [NUM_READ_PORTS-1:0][XLEN-1:0]    rdata_o
);

    logic [NUM_REGS-1:0][XLEN-1:0] regs;

    // Write ports never collide, commit resolves same-register pairs
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            regs <= '0;
        end else begin
            for (int p = 0; p < NUM_LANES; p++) begin
                if (wr_i[p].we && wr_i[p].waddr != '0) begin  // r0 never written
                    regs[wr_i[p].waddr] <= wr_i[p].wdata;
                end
            end
        end
    end

    // Old value on a same-cycle write, dispatch forwards around it
    always_comb begin
        for (int p = 0; p < NUM_READ_PORTS; p++) begin
            rdata_o[p] = (raddr_i[p] == '0) ? '0 : regs[raddr_i[p]];
        end
    end

endmodule

`default_nettype wire

//--- testbench/dual_issue_stim.txt
// Columns: gap pc instr0 instr1 we0 waddr0 wdata0 we1 waddr1 wdata1
// All hex; gap is idle cycles before the strobe, expected values per lane follow
// addi.w r1,r0,0x123 | addi.w r2,r0,-1
3 00001000 02848c01 02bffc02 1 01 00000123 1 02 ffffffff
// add.w r3,r1,r2 | sub.w r4,r1,r2 (gap 0)
0 00001008 00100823 00110824 1 03 00000122 1 04 00000124
// slt r5,r4,r3 | slt r6,r2,r3 (gap 1)
1 00001010 00120c85 00120c46 1 05 00000000 1 06 00000001
// or r7,r6,r1 | xor r8,r2,r6 (gap 2)
2 00001018 001504c7 00159848 1 07 00000123 1 08 fffffffe
// and r9,r8,r7 | andi r10,r2,0xf0f
0 00001020 00149d09 037c3c4a 1 09 00000122 1 0a 00000f0f
// ori r11,r0,0x800 | xori r12,r9,0xfff
0 00001028 03a0000b 03fffd2c 1 0b 00000800 1 0c 00000edd
// addi.w r13,r0,0x7ff | addi.w r14,r13,1 reads old r13
1 00001030 029ffc0d 028005ae 1 0d 000007ff 1 0e 00000001
// Both lanes write r15
0 00001038 0282a80f 0281540f 1 0f 000000aa 1 0f 00000055
// add.w r16,r15,r0 | addi.w r0,r0,5
0 00001040 001001f0 02801400 1 10 00000055 0 00 00000000
// or r17,r15,r0 | add.w r18,r0,r14 (gap 2)
2 00001048 001501f1 00103812 1 11 00000055 1 12 00000001
// Unknown word | sub.w r19,r0,r18
0 00001050 ffffffff 00114813 0 1f 00000000 1 13 ffffffff
// add.w r20,r31,r19 | slt r21,r19,r0
1 00001058 00104ff4 00120275 1 14 ffffffff 1 15 00000001

//--- testbench/tb_dual_issue_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dual_issue_top import dual_issue_pkg::*; ();

    localparam int    CLK_PERIOD    = 100;
    localparam int    RESET_CYCLES  = 5;
    localparam int    DRIVE_DELAY   = 10;  // Input skew after the rising edge
    localparam int    COMMIT_LAT    = 3;   // Strobe to commit latency in cycles
    localparam int    DRAIN_TIMEOUT = 50;
    localparam int    COLS          = 10;  // Words per stimulus line
    localparam int    MAX_VECS      = 32;
    localparam string STIM_FILE     = "testbench/dual_issue_stim.txt";

    typedef struct packed {
        int                           strobe_cycle;
        lane_result_t [NUM_LANES-1:0] res;  // Expected commit per lane
    } expect_t;

    logic                         clk;
    logic                         arst_n;
    logic                         pair_valid;
    logic         [XLEN-1:0]      pair_pc;
    instr_t       [NUM_LANES-1:0] pair_instr;
    lane_result_t [NUM_LANES-1:0] commit;

    logic [31:0] stim_mem [MAX_VECS*COLS];
    expect_t     exp_q[$];
    int          cycle_cnt    = 0;
    int          err_cnt      = 0;
    int          tests_run    = 0;
    int          tests_passed = 0;

    dual_issue_top u_dut (
        .clk          (clk),
        .arst_n_i     (arst_n),
        .pair_valid_i (pair_valid),
        .pair_pc_i    (pair_pc),
        .pair_instr_i (pair_instr),
        .commit_o     (commit)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    function automatic logic any_commit_valid();
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (commit[i].valid === 1'b1) begin
                seen = 1'b1;
            end
        end
        return seen;
    endfunction

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED %s: expected %h, got %h", name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic check_pair(input expect_t e);
        int errs_before;
        errs_before = err_cnt;
        assert (cycle_cnt - e.strobe_cycle == COMMIT_LAT) else begin
            $display("Pair at pc %h committed %0d cycles after its strobe instead of %0d",
                     e.res[0].pc, cycle_cnt - e.strobe_cycle, COMMIT_LAT);
            err_cnt++;
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            check_word($sformatf("commit_o[%0d].valid", i), commit[i].valid, 1'b1);
            check_word($sformatf("commit_o[%0d].pc", i), commit[i].pc, e.res[i].pc);
            check_word($sformatf("commit_o[%0d].we", i), commit[i].we, e.res[i].we);
            if (e.res[i].we) begin  // Address and data only matter on a write
                check_word($sformatf("commit_o[%0d].waddr", i), commit[i].waddr,
                           e.res[i].waddr);
                check_word($sformatf("commit_o[%0d].wdata", i), commit[i].wdata,
                           e.res[i].wdata);
            end
        end
        tests_run++;
        if (err_cnt == errs_before) begin
            tests_passed++;
            $display("Test %0d at pc %h passed", tests_run, e.res[0].pc);
        end else begin
            $display("Test %0d at pc %h failed", tests_run, e.res[0].pc);
        end
    endtask

    // Commit monitor on the falling edge
    always @(negedge clk) begin
        if (arst_n === 1'b1) begin
            if (any_commit_valid()) begin
                assert (exp_q.size() > 0) else begin
                    $display("commit_o went valid with no pair in flight at cycle %0d",
                             cycle_cnt);
                    err_cnt++;
                end
                if (exp_q.size() > 0) begin
                    check_pair(exp_q.pop_front());
                end
            end else if (exp_q.size() > 0) begin
                assert (cycle_cnt - exp_q[0].strobe_cycle <= COMMIT_LAT) else begin
                    tests_run++;
                    $display("Test %0d at pc %h failed, the pair never committed",
                             tests_run, exp_q[0].res[0].pc);
                    err_cnt++;
                    exp_q.delete(0);
                end
            end
        end
    end

    initial begin
        int      num_vecs;
        int      base;
        int      drain;
        expect_t e;

        arst_n     = 1'b0;
        pair_valid = 1'b0;
        pair_pc    = '0;
        pair_instr = '0;

        $readmemh(STIM_FILE, stim_mem);
        num_vecs = 0;
        while (num_vecs < MAX_VECS && !$isunknown(stim_mem[num_vecs*COLS])) begin
            num_vecs++;
        end
        assert (num_vecs > 0) else begin
            $display("No stimulus lines could be read from %s", STIM_FILE);
            err_cnt++;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        arst_n = 1'b1;

        for (int v = 0; v < num_vecs; v++) begin
            base       = v * COLS;
            pair_valid = 1'b0;
            for (int g = 0; g < int'(stim_mem[base]); g++) begin  // Idle gap
                @(posedge clk);
                #DRIVE_DELAY;
            end
            pair_pc       = stim_mem[base+1];
            pair_instr[0] = stim_mem[base+2];
            pair_instr[1] = stim_mem[base+3];
            pair_valid    = 1'b1;

            e              = '0;
            e.strobe_cycle = cycle_cnt;  // Sampled at the next edge
            for (int i = 0; i < NUM_LANES; i++) begin
                e.res[i].valid = 1'b1;
                e.res[i].pc    = stim_mem[base+1] + i * INSTR_BYTES;
                e.res[i].we    = stim_mem[base+4+3*i][0];
                e.res[i].waddr = stim_mem[base+5+3*i][REG_ADDR_W-1:0];
                e.res[i].wdata = stim_mem[base+6+3*i];
            end
            exp_q.push_back(e);
            @(posedge clk);
            #DRIVE_DELAY;
        end
        pair_valid = 1'b0;

        drain = 0;
        while (exp_q.size() > 0 && drain < DRAIN_TIMEOUT) begin
            @(posedge clk);
            drain++;
        end
        repeat (COMMIT_LAT + 1) @(posedge clk);  // Catch stray commits

        if (exp_q.size() > 0) begin
            $display("Timed out with %0d pairs still waiting to commit", exp_q.size());
        end
        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_passed, tests_run - tests_passed, err_cnt);
        if (exp_q.size() == 0 && err_cnt == 0 && tests_passed == num_vecs) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
